// File: bench/rv_core_tb.sv
// rv_core testbench: runs program tables and compares each write-back and halt with expected values
`timescale 1ns/1ps

module rv_core_tb;

  // cycles allowed for any single wait
  localparam int wait_limit   = 50;
  // cycles the stopped core must stay quiet
  localparam int quiet_cycles = 10;

  // rv32i opcodes used by the programs
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  logic                 clk;
  logic                 reset;
  logic                 imem_we;
  rv_core_pkg::addr_t   imem_addr;
  rv_core_pkg::word_t   imem_wdata;
  rv_core_pkg::addr_t   current_pc;
  rv_core_pkg::word_t   inst;
  logic                 wb_en;
  rv_core_pkg::reg_id_t wb_rd;
  rv_core_pkg::word_t   wb_data;
  logic                 halted;
  logic                 illegal;

  // program words, then expected write-backs in program order
  rv_core_pkg::word_t   program_q[$];
  rv_core_pkg::reg_id_t exp_rd_q[$];
  rv_core_pkg::word_t   exp_data_q[$];
  // pc and word of the writing instruction
  rv_core_pkg::addr_t   exp_pc_q[$];
  rv_core_pkg::word_t   exp_inst_q[$];

  rv_core rv_core_i (
    .clk        (clk),
    .reset      (reset),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .current_pc (current_pc),
    .inst       (inst),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .halted     (halted),
    .illegal    (illegal)
  );

  // 20 ns period
  always #10 clk = ~clk;

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_reg_id(input string what, input rv_core_pkg::reg_id_t expected,
                              input rv_core_pkg::reg_id_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected x%0d, got x%0d", $time, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_word(input string what, input rv_core_pkg::word_t expected,
                            input rv_core_pkg::word_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %h, got %h", $time, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_addr(input string what, input rv_core_pkg::addr_t expected,
                            input rv_core_pkg::addr_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %h, got %h", $time, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %b, got %b", $time, what, expected, actual);
      abort_run();
    end
  endtask

  // instruction encoders, one per rv32i format
  function automatic rv_core_pkg::word_t i_type(input logic [11:0] imm,
      input rv_core_pkg::reg_id_t rs1, input logic [2:0] f3,
      input rv_core_pkg::reg_id_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_core_pkg::word_t r_type(input logic [6:0] f7,
      input rv_core_pkg::reg_id_t rs2, input rv_core_pkg::reg_id_t rs1,
      input logic [2:0] f3, input rv_core_pkg::reg_id_t rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic rv_core_pkg::word_t s_type(input logic [11:0] imm,
      input rv_core_pkg::reg_id_t rs2, input rv_core_pkg::reg_id_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  // offset bit 0 is implied zero
  function automatic rv_core_pkg::word_t b_type(input logic [12:0] imm,
      input rv_core_pkg::reg_id_t rs2, input rv_core_pkg::reg_id_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic rv_core_pkg::word_t u_type(input logic [19:0] imm,
      input rv_core_pkg::reg_id_t rd, input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic rv_core_pkg::word_t j_type(input logic [20:0] imm,
      input rv_core_pkg::reg_id_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  task automatic append_instr(input rv_core_pkg::word_t word);
    program_q.push_back(word);
  endtask

  // belongs to the instruction appended last, which sits at 4 * index
  task automatic expect_write(input rv_core_pkg::reg_id_t rd, input rv_core_pkg::word_t data);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
    exp_pc_q.push_back(rv_core_pkg::addr_t'(4 * (program_q.size() - 1)));
    exp_inst_q.push_back(program_q[program_q.size() - 1]);
  endtask

  // main run, word index i sits at byte address 4*i
  task automatic main_program();
    rv_core_pkg::word_t rnd;
    logic [11:0]        imm_a;
    logic [11:0]        imm_b;
    rv_core_pkg::word_t x1;
    rv_core_pkg::word_t x2;
    rnd   = $urandom;
    imm_a = rnd[11:0];
    rnd   = $urandom;
    imm_b = rnd[11:0];
    // addi sign-extends its 12-bit immediate
    x1 = {{20{imm_a[11]}}, imm_a};
    x2 = {{20{imm_b[11]}}, imm_b};
    program_q.delete();
    exp_rd_q.delete();
    exp_data_q.delete();
    exp_pc_q.delete();
    exp_inst_q.delete();
    append_instr(i_type(imm_a, 5'd0, 3'b000, 5'd1, opc_op_imm));
    expect_write(5'd1, x1);
    append_instr(i_type(imm_b, 5'd0, 3'b000, 5'd2, opc_op_imm));
    expect_write(5'd2, x2);
    // register-register alu ops on the random pair
    append_instr(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));
    expect_write(5'd3, x1 + x2);
    append_instr(r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4));
    expect_write(5'd4, x1 - x2);
    append_instr(r_type(7'b0000000, 5'd2, 5'd1, 3'b111, 5'd5));
    expect_write(5'd5, x1 & x2);
    append_instr(r_type(7'b0000000, 5'd2, 5'd1, 3'b110, 5'd6));
    expect_write(5'd6, x1 | x2);
    append_instr(r_type(7'b0000000, 5'd2, 5'd1, 3'b100, 5'd7));
    expect_write(5'd7, x1 ^ x2);
    append_instr(r_type(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd8));
    expect_write(5'd8, ($signed(x1) < $signed(x2)) ? 32'd1 : 32'd0);
    append_instr(r_type(7'b0000000, 5'd2, 5'd1, 3'b011, 5'd9));
    expect_write(5'd9, (x1 < x2) ? 32'd1 : 32'd0);
    append_instr(u_type(20'h12345, 5'd10, opc_lui));
    expect_write(5'd10, 32'h1234_5000);
    // auipc at pc 0x28
    append_instr(u_type(20'h00001, 5'd11, opc_auipc));
    expect_write(5'd11, 32'h0000_1028);
    // x0 target, no write-back, then x0 + x0
    append_instr(i_type(12'd5, 5'd1, 3'b000, 5'd0, opc_op_imm));
    append_instr(r_type(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd12));
    expect_write(5'd12, 32'h0000_0000);
    // store word, read back whole word and two bytes
    append_instr(u_type(20'h8badf, 5'd13, opc_lui));
    expect_write(5'd13, 32'h8bad_f000);
    append_instr(i_type(12'h0e5, 5'd13, 3'b000, 5'd13, opc_op_imm));
    expect_write(5'd13, 32'h8bad_f0e5);
    append_instr(s_type(12'd16, 5'd13, 5'd0, 3'b010));
    append_instr(i_type(12'd16, 5'd0, 3'b010, 5'd14, opc_load));
    expect_write(5'd14, 32'h8bad_f0e5);
    // lb of byte 1 (0xf0), lbu of byte 0 (0xe5)
    append_instr(i_type(12'd17, 5'd0, 3'b000, 5'd15, opc_load));
    expect_write(5'd15, 32'hffff_fff0);
    append_instr(i_type(12'd16, 5'd0, 3'b100, 5'd16, opc_load));
    expect_write(5'd16, 32'h0000_00e5);
    // taken beq skips index 20
    append_instr(b_type(13'd8, 5'd1, 5'd1, 3'b000));
    append_instr(i_type(12'd1, 5'd0, 3'b000, 5'd17, opc_op_imm));
    // not-taken bne falls through
    append_instr(b_type(13'd8, 5'd1, 5'd1, 3'b001));
    append_instr(i_type(12'd2, 5'd0, 3'b000, 5'd18, opc_op_imm));
    expect_write(5'd18, 32'd2);
    // jal at pc 92 links 96 and lands on index 25
    append_instr(j_type(21'd8, 5'd19));
    expect_write(5'd19, 32'd96);
    append_instr(i_type(12'd3, 5'd0, 3'b000, 5'd20, opc_op_imm));
    // jalr at pc 100 to 113 with bit 0 cleared, index 28
    append_instr(i_type(12'd113, 5'd0, 3'b000, 5'd21, opc_jalr));
    expect_write(5'd21, 32'd104);
    append_instr(i_type(12'd4, 5'd0, 3'b000, 5'd22, opc_op_imm));
    append_instr(i_type(12'd5, 5'd0, 3'b000, 5'd23, opc_op_imm));
    append_instr(i_type(12'd6, 5'd0, 3'b000, 5'd24, opc_op_imm));
    expect_write(5'd24, 32'd6);
    // ebreak
    append_instr(32'h0010_0073);
  endtask

  // second run: one write, then an unknown opcode
  task automatic illegal_program();
    program_q.delete();
    exp_rd_q.delete();
    exp_data_q.delete();
    exp_pc_q.delete();
    exp_inst_q.delete();
    append_instr(i_type(12'd7, 5'd0, 3'b000, 5'd5, opc_op_imm));
    expect_write(5'd5, 32'd7);
    append_instr(32'hffff_ffff);
  endtask

  // program written while reset is held, reset kept 4 cycles after the load
  task automatic load_program();
    @(negedge clk);
    reset = 1'b1;
    foreach (program_q[i]) begin
      @(negedge clk);
      imem_we    = 1'b1;
      imem_addr  = rv_core_pkg::addr_t'(4 * i);
      imem_wdata = program_q[i];
    end
    @(negedge clk);
    imem_we = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
  endtask

  // outputs sampled mid-cycle, one write-back per wb_en cycle
  task automatic follow_write_backs();
    int cycles;
    foreach (exp_rd_q[n]) begin
      cycles = 0;
      @(negedge clk);
      while (wb_en !== 1'b1) begin
        if (halted === 1'b1) begin
          $display("core halted before write-back %0d at %0t", n, $time);
          abort_run();
        end
        cycles++;
        if (cycles > wait_limit) begin
          $display("timed out waiting for write-back %0d at %0t", n, $time);
          abort_run();
        end
        @(negedge clk);
      end
      check_reg_id($sformatf("write-back %0d rd", n), exp_rd_q[n], wb_rd);
      check_word($sformatf("write-back %0d data", n), exp_data_q[n], wb_data);
      check_addr($sformatf("write-back %0d pc", n), exp_pc_q[n], current_pc);
      check_word($sformatf("write-back %0d inst", n), exp_inst_q[n], inst);
    end
  endtask

  task automatic check_halt(input logic exp_illegal);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (halted !== 1'b1) begin
      if (wb_en === 1'b1) begin
        $display("unexpected write-back to x%0d before halt at %0t", wb_rd, $time);
        abort_run();
      end
      cycles++;
      if (cycles > wait_limit) begin
        $display("timed out waiting for halted at %0t", $time);
        abort_run();
      end
      @(negedge clk);
    end
    check_flag("illegal", exp_illegal, illegal);
    // halting word is the last one in the program and stays in execute
    check_addr("halted pc", rv_core_pkg::addr_t'(4 * (program_q.size() - 1)), current_pc);
    check_word("halted inst", program_q[program_q.size() - 1], inst);
    // stopped core stays halted and silent
    repeat (quiet_cycles) begin
      @(negedge clk);
      if (wb_en !== 1'b0 || halted !== 1'b1) begin
        $display("core wrote back or left the halted state at %0t", $time);
        abort_run();
      end
    end
  endtask

  initial begin
    void'($urandom(32'h2793));
    clk        = 1'b0;
    reset      = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    main_program();
    load_program();
    follow_write_backs();
    check_halt(1'b0);
    // fresh reset with the illegal word
    illegal_program();
    load_program();
    follow_write_backs();
    check_halt(1'b1);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: rv_core.f
+incdir+src
src/rv_core_pkg.sv
src/decode_ctrl_if.sv
src/instr_decoder.sv
src/fetch_unit.sv
src/register_file.sv
src/execute_unit.sv
src/data_memory.sv
src/rv_core.sv
bench/rv_core_tb.sv

// File: src/data_memory.sv
// data memory: word RAM with word and byte-lane stores, sign or zero extended loads
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module data_memory (
  input  logic               clk,
  input  rv_core_pkg::addr_t addr,
  input  rv_core_pkg::word_t wdata,
  decode_ctrl_if.memory      ctrl,
  output rv_core_pkg::word_t rdata
);
  localparam int dmem_aw = $clog2(`RV_DMEM_DEPTH);

  rv_core_pkg::word_t mem [`RV_DMEM_DEPTH];
  logic [dmem_aw-1:0] index;
  logic [1:0]         lane;
  rv_core_pkg::word_t rd_word;
  logic [7:0]         sel_byte;

  assign index = addr[dmem_aw+1:2];
  assign lane  = addr[1:0];

  // store at the end of the execute cycle
  always_ff @(posedge clk) begin
    if (ctrl.mem_wen) begin
      if (ctrl.mem_width == rv_core_pkg::mem_word) begin
        mem[index] <= wdata;
      end else begin
        // byte goes to the addressed lane only
        mem[index][8*lane +: 8] <= wdata[7:0];
      end
    end
  end

  assign rd_word  = mem[index];
  assign sel_byte = rd_word[8*lane +: 8];

  always_comb begin
    if (!ctrl.is_load) begin
      rdata = '0;
    end else if (ctrl.mem_width == rv_core_pkg::mem_word) begin
      rdata = rd_word;
    end else if (ctrl.load_unsigned) begin
      // lbu
      rdata = {{(`RV_XLEN-8){1'b0}}, sel_byte};
    end else begin
      // lb
      rdata = {{(`RV_XLEN-8){sel_byte[7]}}, sel_byte};
    end
  end

  // word loads and stores must be aligned
  assert property (@(posedge clk)
    (ctrl.is_load || ctrl.mem_wen) && ctrl.mem_width == rv_core_pkg::mem_word
      |-> addr[1:0] == 2'b00)
    else $error("misaligned word access at %h", addr);

endmodule

// File: src/decode_ctrl_if.sv
// decoded control bundle from the instruction decoder to the datapath
`timescale 1ns/1ps

interface decode_ctrl_if;

  // alu and operand select
  rv_core_pkg::alu_op_e    alu_op;
  logic                    use_imm;
  logic                    use_pc;
  rv_core_pkg::word_t      imm;

  // flow control, already qualified by valid
  logic                    is_jump;
  logic                    is_branch;

  // write-back and memory
  logic                    is_load;
  logic                    reg_wen;
  rv_core_pkg::reg_id_t    rd;
  logic                    mem_wen;
  rv_core_pkg::mem_width_e mem_width;
  logic                    load_unsigned;

  modport decoder (
    output alu_op, use_imm, use_pc, imm, is_jump, is_branch,
    output is_load, reg_wen, rd, mem_wen, mem_width, load_unsigned
  );

  modport execute (
    input alu_op, use_imm, use_pc, is_jump, is_branch, is_load, reg_wen, rd, imm
  );

  modport memory (
    input is_load, mem_wen, mem_width, load_unsigned
  );

endinterface

// File: src/execute_unit.sv
// execute unit: operand select, ALU, branch and jump redirect, write-back select
`timescale 1ns/1ps

module execute_unit (
  input  rv_core_pkg::addr_t   pc,
  input  rv_core_pkg::word_t   rdata1,
  input  rv_core_pkg::word_t   rdata2,
  decode_ctrl_if.execute       ctrl,
  input  rv_core_pkg::word_t   load_data,
  output rv_core_pkg::addr_t   mem_addr,
  output rv_core_pkg::word_t   store_data,
  output logic                 redirect,
  output rv_core_pkg::addr_t   target,
  output logic                 wb_en,
  output rv_core_pkg::reg_id_t wb_rd,
  output rv_core_pkg::word_t   wb_data
);
  rv_core_pkg::word_t op_a;
  rv_core_pkg::word_t op_b;
  rv_core_pkg::word_t alu_result;
  rv_core_pkg::addr_t branch_target;
  rv_core_pkg::addr_t jump_target;

  // pc for auipc and jal
  assign op_a = ctrl.use_pc ? pc : rdata1;
  assign op_b = ctrl.use_imm ? ctrl.imm : rdata2;

  always_comb begin
    case (ctrl.alu_op)
      rv_core_pkg::alu_add:    alu_result = op_a + op_b;
      rv_core_pkg::alu_sub:    alu_result = op_a - op_b;
      rv_core_pkg::alu_and:    alu_result = op_a & op_b;
      rv_core_pkg::alu_or:     alu_result = op_a | op_b;
      rv_core_pkg::alu_xor:    alu_result = op_a ^ op_b;
      rv_core_pkg::alu_slt:    alu_result = rv_core_pkg::word_t'($signed(op_a) < $signed(op_b));
      rv_core_pkg::alu_sltu:   alu_result = rv_core_pkg::word_t'(op_a < op_b);
      rv_core_pkg::alu_eq:     alu_result = rv_core_pkg::word_t'(op_a == op_b);
      rv_core_pkg::alu_ne:     alu_result = rv_core_pkg::word_t'(op_a != op_b);
      rv_core_pkg::alu_pass_b: alu_result = op_b;
      default:                 alu_result = '0;
    endcase
  end

  // branch offset is relative to the branch itself
  assign branch_target = pc + ctrl.imm;
  // jal and jalr both drop bit 0
  assign jump_target   = {alu_result[$bits(alu_result)-1:1], 1'b0};

  // compare result sits in bit 0
  assign redirect = ctrl.is_jump | (ctrl.is_branch & alu_result[0]);
  assign target   = ctrl.is_jump ? jump_target : branch_target;

  // effective address for loads and stores
  assign mem_addr   = alu_result;
  assign store_data = rdata2;

  // writes to x0 are not reported
  assign wb_en = ctrl.reg_wen & (ctrl.rd != '0);
  assign wb_rd = ctrl.rd;

  always_comb begin
    if (ctrl.is_jump) begin
      // link address
      wb_data = pc + rv_core_pkg::addr_t'(4);
    end else if (ctrl.is_load) begin
      wb_data = load_data;
    end else begin
      wb_data = alu_result;
    end
  end

endmodule

// File: src/fetch_unit.sv
// fetch unit: program counter, instruction RAM with load port and fetch/decode register
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module fetch_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               redirect,
  input  rv_core_pkg::addr_t target,
  input  logic               halt,
  input  logic               imem_we,
  input  rv_core_pkg::addr_t imem_addr,
  input  rv_core_pkg::word_t imem_wdata,
  output rv_core_pkg::addr_t pc,
  output rv_core_pkg::word_t inst,
  output logic               valid,
  output logic               halted
);
  localparam int imem_aw = $clog2(`RV_IMEM_DEPTH);

  rv_core_pkg::word_t imem [`RV_IMEM_DEPTH];
  rv_core_pkg::addr_t fetch_pc;
  logic               freeze;

  // stop on the halting edge and stay stopped
  assign freeze = halt | halted;

  // program load port, word addressed
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr[imem_aw+1:2]] <= imem_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_pc <= `RV_RESET_PC;
      valid    <= 1'b0;
      halted   <= 1'b0;
    end else begin
      if (halt) begin
        halted <= 1'b1;
      end
      if (!freeze) begin
        fetch_pc <= redirect ? target : fetch_pc + rv_core_pkg::addr_t'(4);
        // redirect drops the word fetched behind the jump
        valid    <= ~redirect;
      end
    end
  end

  // fetch/decode payload
  always_ff @(posedge clk) begin
    if (!freeze) begin
      inst <= imem[fetch_pc[imem_aw+1:2]];
      pc   <= fetch_pc;
    end
  end

  // program is only loaded while the core is held in reset
  assert property (@(posedge clk) imem_we |-> reset)
    else $error("imem_we asserted outside reset");

endmodule

// File: src/instr_decoder.sv
// instruction decoder: splits the fetched word into indices, immediate and control levels
`timescale 1ns/1ps

module instr_decoder (
  input  rv_core_pkg::word_t   inst,
  input  logic                 valid,
  input  logic                 halt_state,
  output rv_core_pkg::reg_id_t rs1,
  output rv_core_pkg::reg_id_t rs2,
  decode_ctrl_if.decoder       ctrl,
  output logic                 is_ebreak,
  output logic                 is_illegal
);
  // major opcodes of the supported subset
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam rv_core_pkg::word_t ebreak_word = 32'h0010_0073;

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  rv_core_pkg::word_t imm_i;
  rv_core_pkg::word_t imm_s;
  rv_core_pkg::word_t imm_b;
  rv_core_pkg::word_t imm_u;
  rv_core_pkg::word_t imm_j;
  logic               reg_w;
  logic               mem_w;
  logic               jump;
  logic               branch;
  logic               load;
  logic               ebreak;
  logic               illegal;
  logic               live;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign ctrl.rd = inst[11:7];

  // immediate formats, all sign-extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl.alu_op        = rv_core_pkg::alu_add;
    ctrl.use_imm       = 1'b0;
    ctrl.use_pc        = 1'b0;
    ctrl.imm           = imm_i;
    ctrl.mem_width     = rv_core_pkg::mem_word;
    ctrl.load_unsigned = 1'b0;
    reg_w   = 1'b0;
    mem_w   = 1'b0;
    jump    = 1'b0;
    branch  = 1'b0;
    load    = 1'b0;
    ebreak  = 1'b0;
    illegal = 1'b0;
    case (opcode)
      opc_op_imm: begin
        // addi only
        ctrl.use_imm = 1'b1;
        reg_w        = (funct3 == 3'b000);
        illegal      = (funct3 != 3'b000);
      end
      opc_op: begin
        reg_w = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl.alu_op = rv_core_pkg::alu_add;
          10'b0100000_000: ctrl.alu_op = rv_core_pkg::alu_sub;
          10'b0000000_111: ctrl.alu_op = rv_core_pkg::alu_and;
          10'b0000000_110: ctrl.alu_op = rv_core_pkg::alu_or;
          10'b0000000_100: ctrl.alu_op = rv_core_pkg::alu_xor;
          10'b0000000_010: ctrl.alu_op = rv_core_pkg::alu_slt;
          10'b0000000_011: ctrl.alu_op = rv_core_pkg::alu_sltu;
          default: begin
            reg_w   = 1'b0;
            illegal = 1'b1;
          end
        endcase
      end
      opc_lui: begin
        ctrl.alu_op  = rv_core_pkg::alu_pass_b;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        reg_w        = 1'b1;
      end
      opc_auipc: begin
        ctrl.use_pc  = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        reg_w        = 1'b1;
      end
      opc_jal: begin
        // target pc + imm comes out of the alu
        ctrl.use_pc  = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_j;
        jump         = 1'b1;
        reg_w        = 1'b1;
      end
      opc_jalr: begin
        ctrl.use_imm = 1'b1;
        jump         = (funct3 == 3'b000);
        reg_w        = (funct3 == 3'b000);
        illegal      = (funct3 != 3'b000);
      end
      opc_branch: begin
        // beq and bne compare rs1 with rs2
        ctrl.imm    = imm_b;
        ctrl.alu_op = (funct3[0]) ? rv_core_pkg::alu_ne : rv_core_pkg::alu_eq;
        branch      = (funct3[2:1] == 2'b00);
        illegal     = (funct3[2:1] != 2'b00);
      end
      opc_load: begin
        ctrl.use_imm       = 1'b1;
        ctrl.load_unsigned = funct3[2];
        ctrl.mem_width     = (funct3 == 3'b010) ? rv_core_pkg::mem_word
                                                : rv_core_pkg::mem_byte;
        // lb, lw and lbu
        if (funct3 == 3'b000 || funct3 == 3'b010 || funct3 == 3'b100) begin
          load  = 1'b1;
          reg_w = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      opc_store: begin
        // sw only
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_s;
        mem_w        = (funct3 == 3'b010);
        illegal      = (funct3 != 3'b010);
      end
      opc_system: begin
        ebreak  = (inst == ebreak_word);
        illegal = (inst != ebreak_word);
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // nothing acts from a bubble or once the core has stopped
  assign live = valid & ~halt_state;

  assign ctrl.reg_wen   = reg_w & live;
  assign ctrl.mem_wen   = mem_w & live;
  assign ctrl.is_jump   = jump & live;
  assign ctrl.is_branch = branch & live;
  assign ctrl.is_load   = load & live;

  // held in decode while halted, so these stay up
  assign is_ebreak  = ebreak & valid;
  assign is_illegal = illegal & valid;

endmodule

// File: src/register_file.sv
// register file: 32 registers, two combinational reads, one synchronous write, x0 reads zero
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module register_file (
  input  logic                 clk,
  input  rv_core_pkg::reg_id_t rs1,
  input  rv_core_pkg::reg_id_t rs2,
  output rv_core_pkg::word_t   rdata1,
  output rv_core_pkg::word_t   rdata2,
  input  logic                 wen,
  input  rv_core_pkg::reg_id_t rd,
  input  rv_core_pkg::word_t   wdata
);
  localparam int num_regs = 2 ** `RV_REG_ID_W;

  rv_core_pkg::word_t regs [num_regs];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 forced to zero on read
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: src/rv_core.sv
// rv_core top: two-stage RV32I subset core with program load port and halt outputs
`timescale 1ns/1ps

module rv_core (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 imem_we,
  input  rv_core_pkg::addr_t   imem_addr,
  input  rv_core_pkg::word_t   imem_wdata,
  output rv_core_pkg::addr_t   current_pc,
  output rv_core_pkg::word_t   inst,
  output logic                 wb_en,
  output rv_core_pkg::reg_id_t wb_rd,
  output rv_core_pkg::word_t   wb_data,
  output logic                 halted,
  output logic                 illegal
);
  logic                 valid;
  logic                 redirect;
  rv_core_pkg::addr_t   target;
  logic                 is_ebreak;
  logic                 halt_req;
  rv_core_pkg::reg_id_t rs1;
  rv_core_pkg::reg_id_t rs2;
  rv_core_pkg::word_t   rdata1;
  rv_core_pkg::word_t   rdata2;
  rv_core_pkg::addr_t   mem_addr;
  rv_core_pkg::word_t   store_data;
  rv_core_pkg::word_t   load_data;

  decode_ctrl_if ctrl_if ();

  // either event stops fetch
  assign halt_req = is_ebreak | illegal;

  fetch_unit fetch_unit_i (
    .clk        (clk),
    .reset      (reset),
    .redirect   (redirect),
    .target     (target),
    .halt       (halt_req),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .pc         (current_pc),
    .inst       (inst),
    .valid      (valid),
    .halted     (halted)
  );

  instr_decoder instr_decoder_i (
    .inst       (inst),
    .valid      (valid),
    .halt_state (halted),
    .rs1        (rs1),
    .rs2        (rs2),
    .ctrl       (ctrl_if.decoder),
    .is_ebreak  (is_ebreak),
    .is_illegal (illegal)
  );

  register_file register_file_i (
    .clk    (clk),
    .rs1    (rs1),
    .rs2    (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wen    (wb_en),
    .rd     (wb_rd),
    .wdata  (wb_data)
  );

  execute_unit execute_unit_i (
    .pc         (current_pc),
    .rdata1     (rdata1),
    .rdata2     (rdata2),
    .ctrl       (ctrl_if.execute),
    .load_data  (load_data),
    .mem_addr   (mem_addr),
    .store_data (store_data),
    .redirect   (redirect),
    .target     (target),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  data_memory data_memory_i (
    .clk   (clk),
    .addr  (mem_addr),
    .wdata (store_data),
    .ctrl  (ctrl_if.memory),
    .rdata (load_data)
  );

endmodule

// File: src/rv_core_defines.svh
// rv_core defines: datapath widths, memory depths and the reset program counter
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// data and instruction width
`define RV_XLEN 32

// register index width, 32 architectural registers
`define RV_REG_ID_W 5

// memory depths in 32-bit words
`define RV_IMEM_DEPTH 256
`define RV_DMEM_DEPTH 256

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: src/rv_core_pkg.sv
// rv_core package: shared word, index and address types and control encodings
`include "rv_core_defines.svh"

package rv_core_pkg;

  // data or instruction word
  typedef logic [`RV_XLEN-1:0] word_t;

  // register index
  typedef logic [`RV_REG_ID_W-1:0] reg_id_t;

  // byte address
  typedef logic [`RV_XLEN-1:0] addr_t;

  // alu operations
  // eq and ne give the branch compare in bit 0
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_eq,
    alu_ne,
    alu_pass_b
  } alu_op_e;

  // load/store access width
  typedef enum logic {
    mem_byte,
    mem_word
  } mem_width_e;

endpackage
